// ==== include/tlb_defs.svh ====
/*
 TLB geometry and address macros, shared by the design and its testbench
*/
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// virtual and physical addresses are the same width
`define TLB_VADDR_W    48
`define TLB_PAGE_SHIFT 12
`define TLB_VPN_W      36

// 16 sets of 4 ways
`define TLB_INDEX_W    4
`define TLB_SETS       16
`define TLB_WAYS       4

// Wishbone data word that carries an LDTLB entry in its low bits
`define TLB_ENTRY_W    80

// page returned on a miss
`define TLB_MISS_PAGE  36'h10

`endif

// ==== rtl/tlbPkg.sv ====
/*
 TLB types: request opcodes, exception codes and the stored entry
*/
`default_nettype none

`include "tlb_defs.svh"

package tlbPkg;

	// request kinds on the Wishbone port
	typedef enum logic [1:0] {
		opLoad   = 2'd0,
		opStore  = 2'd1,
		opLdtlb  = 2'd2,
		opInvtlb = 2'd3
	} tlbOpT;

	typedef enum logic [1:0] {
		excNone      = 2'd0,
		excMiss      = 2'd1,
		excWriteProt = 2'd2
	} tlbExcT;

	// one translation, 73 bits
	// vpn is the tag, ppn the replacement page
	typedef struct packed {
		logic [`TLB_VPN_W-1:0] vpn;
		logic [`TLB_VPN_W-1:0] ppn;
		logic                  writable;
	} tlbEntryT;

endpackage

`default_nettype wire

// ==== rtl/tlbIf.sv ====
/*
 TLB internal buses: the set lookup from the request stage, with its
 copy one cycle later, and the set fill from the translate stage
*/
`default_nettype none
`timescale 1ns/1ps

`include "tlb_defs.svh"

interface tlbLookupIf;
	import tlbPkg::*;

	logic                      lookValid;
	logic [`TLB_INDEX_W-1:0]   lookIndex;
	tlbOpT                     lookOp;
	logic [`TLB_VADDR_W-1:0]   lookAdr;
	tlbEntryT                  lookEntry;
	logic                      lookBypass;

	// same fields aligned with the registered set read
	logic                      stageValid;
	logic [`TLB_INDEX_W-1:0]   stageIndex;
	tlbOpT                     stageOp;
	logic [`TLB_VADDR_W-1:0]   stageAdr;
	tlbEntryT                  stageEntry;
	logic                      stageBypass;

	modport request (output lookValid, lookIndex, lookOp, lookAdr, lookEntry, lookBypass);

	modport array (
		input  lookValid, lookIndex, lookOp, lookAdr, lookEntry, lookBypass,
		output stageValid, stageIndex, stageOp, stageAdr, stageEntry, stageBypass
	);

	modport translate (input stageValid, stageIndex, stageOp, stageAdr, stageEntry, stageBypass);
endinterface

interface tlbFillIf;
	import tlbPkg::*;

	logic                          fillWrite;
	logic                          fillClear;
	logic [`TLB_INDEX_W-1:0]       fillIndex;
	tlbEntryT [`TLB_WAYS-1:0]      fillWays;
	logic [`TLB_WAYS-1:0]          fillValid;

	modport fill (output fillWrite, fillClear, fillIndex, fillWays, fillValid);
	modport array (input fillWrite, fillClear, fillIndex, fillWays, fillValid);
endinterface

`default_nettype wire

// ==== rtl/tlbRequestStage.sv ====
/*
 TLB request stage: takes one Wishbone request when idle, picks the set
 to read and the bypass decision, and stays busy until the acknowledge
*/
`default_nettype none
`timescale 1ns/1ps

`include "tlb_defs.svh"

module tlbRequestStage (
	input  wire logic                      clock,
	input  wire logic                      reset,
	input  wire logic                      cyc,
	input  wire logic                      stb,
	input  wire tlbPkg::tlbOpT             op,
	input  wire logic [`TLB_VADDR_W-1:0]   adr,
	input  wire logic [`TLB_ENTRY_W-1:0]   datIn,
	input  wire logic                      mmuEnable,
	input  wire logic                      ack,
	tlbLookupIf.request                    look
);
	import tlbPkg::*;

	localparam int entryW = $bits(tlbEntryT);
	// physical window, top nibble C or D
	localparam logic [3:0] physWinC = 4'hC;
	localparam logic [3:0] physWinD = 4'hD;

	logic       busy;
	logic       accept;
	tlbEntryT   reqEntry;
	logic [3:0] topNibble;

	// entry sits in the low bits of the data word
	assign reqEntry  = tlbEntryT'(datIn[entryW-1:0]);
	assign topNibble = adr[`TLB_VADDR_W-1 -: 4];
	assign accept    = cyc && stb && !busy;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy           <= 1'b0;
			look.lookValid <= 1'b0;
		end
		else
		begin
			look.lookValid <= accept;
			if (accept)
			begin
				busy <= 1'b1;
			end
			else if (ack)
			begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			look.lookOp    <= op;
			look.lookAdr   <= adr;
			look.lookEntry <= reqEntry;
			// LDTLB writes the set of the new entry, not of adr
			if (op == opLdtlb)
			begin
				look.lookIndex <= reqEntry.vpn[`TLB_INDEX_W-1:0];
			end
			else
			begin
				look.lookIndex <= adr[`TLB_PAGE_SHIFT +: `TLB_INDEX_W];
			end
			look.lookBypass <= !mmuEnable || (topNibble == physWinC) ||
				(topNibble == physWinD);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tlbWayArray.sv ====
/*
 TLB way array: 16 sets of 4 entries with valid flags, one registered
 read per lookup, whole-set writes and a global invalidate
*/
`default_nettype none
`timescale 1ns/1ps

`include "tlb_defs.svh"

module tlbWayArray (
	input  wire logic                          clock,
	input  wire logic                          reset,
	tlbLookupIf.array                          look,
	tlbFillIf.array                            fill,
	output tlbPkg::tlbEntryT [`TLB_WAYS-1:0]   readWays,
	output logic [`TLB_WAYS-1:0]               readValid
);
	import tlbPkg::*;

	tlbEntryT [`TLB_WAYS-1:0] setMem [`TLB_SETS];
	logic [`TLB_WAYS-1:0]     validMem [`TLB_SETS];

	// entry storage
	always_ff @(posedge clock)
	begin
		if (fill.fillWrite)
		begin
			setMem[fill.fillIndex] <= fill.fillWays;
		end
		if (look.lookValid)
		begin
			readWays <= setMem[look.lookIndex];
		end
	end

	// valid flags, cleared all at once
	always_ff @(posedge clock)
	begin
		if (reset || fill.fillClear)
		begin
			for (int s = 0; s < `TLB_SETS; s++)
			begin
				validMem[s] <= '0;
			end
		end
		else if (fill.fillWrite)
		begin
			validMem[fill.fillIndex] <= fill.fillValid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			readValid <= '0;
		end
		else if (look.lookValid)
		begin
			readValid <= validMem[look.lookIndex];
		end
	end

	// request fields follow the read by one cycle
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			look.stageValid <= 1'b0;
		end
		else
		begin
			look.stageValid <= look.lookValid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (look.lookValid)
		begin
			look.stageIndex  <= look.lookIndex;
			look.stageOp     <= look.lookOp;
			look.stageAdr    <= look.lookAdr;
			look.stageEntry  <= look.lookEntry;
			look.stageBypass <= look.lookBypass;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tlbTranslate.sv ====
/*
 TLB translate stage: compares the four tags, forms the physical address
 and exception, issues LDTLB fills and INVTLB clears, and registers the
 Wishbone acknowledge with the result
*/
`default_nettype none
`timescale 1ns/1ps

`include "tlb_defs.svh"

module tlbTranslate (
	input  wire logic                          clock,
	input  wire logic                          reset,
	tlbLookupIf.translate                      stage,
	input  wire tlbPkg::tlbEntryT [`TLB_WAYS-1:0] readWays,
	input  wire logic [`TLB_WAYS-1:0]          readValid,
	tlbFillIf.fill                             fill,
	output logic                               ack,
	output logic [`TLB_VADDR_W-1:0]            physAdr,
	output tlbPkg::tlbExcT                     exc
);
	import tlbPkg::*;

	// bypassed and low translated addresses land in window C
	localparam logic [3:0] physWin = 4'hC;
	localparam int topBit = `TLB_VADDR_W - 1;

	logic [`TLB_VPN_W-1:0]      reqVpn;
	logic [`TLB_PAGE_SHIFT-1:0] reqOffset;
	logic [`TLB_WAYS-1:0]       wayHit;
	logic                       anyHit;
	logic                       isAccess;
	tlbEntryT                   hitEntry;
	logic [`TLB_VADDR_W-1:0]    hitAdr;
	logic [`TLB_VADDR_W-1:0]    nextAdr;
	tlbExcT                     nextExc;

	assign reqVpn    = stage.stageAdr[`TLB_VADDR_W-1:`TLB_PAGE_SHIFT];
	assign reqOffset = stage.stageAdr[`TLB_PAGE_SHIFT-1:0];
	assign isAccess  = (stage.stageOp == opLoad) || (stage.stageOp == opStore);

	// tag compare per way
	always_comb
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
		begin
			wayHit[w] = readValid[w] && (readWays[w].vpn == reqVpn);
		end
	end

	assign anyHit = |wayHit;

	// lowest hitting way wins, way 0 holds the newest insert
	always_comb
	begin
		hitEntry = readWays[0];
		for (int w = `TLB_WAYS - 1; w >= 0; w--)
		begin
			if (wayHit[w])
			begin
				hitEntry = readWays[w];
			end
		end
	end

	always_comb
	begin
		hitAdr = {hitEntry.ppn, reqOffset};
		if (hitAdr[topBit -: 4] == 4'h0)
		begin
			hitAdr[topBit -: 4] = physWin;
		end
	end

	// LDTLB and INVTLB pass the address through with no exception
	always_comb
	begin
		nextAdr = stage.stageAdr;
		nextExc = excNone;
		if (isAccess)
		begin
			if (stage.stageBypass)
			begin
				nextAdr[topBit -: 4] = physWin;
			end
			else if (!anyHit)
			begin
				nextAdr = {`TLB_MISS_PAGE, reqOffset};
				nextExc = excMiss;
			end
			else
			begin
				nextAdr = hitAdr;
				if ((stage.stageOp == opStore) && !hitEntry.writable)
				begin
					nextExc = excWriteProt;
				end
			end
		end
	end

	// new entry enters way 0, ways 0..2 shift down, way 3 drops out
	assign fill.fillWrite = stage.stageValid && (stage.stageOp == opLdtlb);
	assign fill.fillClear = stage.stageValid && (stage.stageOp == opInvtlb);
	assign fill.fillIndex = stage.stageIndex;
	assign fill.fillWays  = {readWays[`TLB_WAYS-2:0], stage.stageEntry};
	assign fill.fillValid = {readValid[`TLB_WAYS-2:0], 1'b1};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ack <= 1'b0;
		end
		else
		begin
			ack <= stage.stageValid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (stage.stageValid)
		begin
			physAdr <= nextAdr;
			exc     <= nextExc;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mmuTlb.sv ====
/*
 MMU TLB top: a 4-way, 16-set translation buffer behind a Wishbone
 classic slave port, built from request, way array and translate stages
*/
`default_nettype none
`timescale 1ns/1ps

`include "tlb_defs.svh"

module mmuTlb (
	input  wire logic                      clock,
	input  wire logic                      reset,
	input  wire logic                      cyc,
	input  wire logic                      stb,
	input  wire tlbPkg::tlbOpT             op,
	input  wire logic [`TLB_VADDR_W-1:0]   adr,
	input  wire logic [`TLB_ENTRY_W-1:0]   datIn,
	input  wire logic                      mmuEnable,
	output logic                           ack,
	output logic [`TLB_VADDR_W-1:0]        physAdr,
	output tlbPkg::tlbExcT                 exc
);
	import tlbPkg::*;

	// set read, one cycle after the lookup
	tlbEntryT [`TLB_WAYS-1:0] readWays;
	logic [`TLB_WAYS-1:0]     readValid;

	tlbLookupIf look ();
	tlbFillIf   fill ();

	tlbRequestStage requestStage (
		.clock     (clock),
		.reset     (reset),
		.cyc       (cyc),
		.stb       (stb),
		.op        (op),
		.adr       (adr),
		.datIn     (datIn),
		.mmuEnable (mmuEnable),
		.ack       (ack),
		.look      (look.request)
	);

	tlbWayArray wayArray (
		.clock     (clock),
		.reset     (reset),
		.look      (look.array),
		.fill      (fill.array),
		.readWays  (readWays),
		.readValid (readValid)
	);

	tlbTranslate translateStage (
		.clock     (clock),
		.reset     (reset),
		.stage     (look.translate),
		.readWays  (readWays),
		.readValid (readValid),
		.fill      (fill.fill),
		.ack       (ack),
		.physAdr   (physAdr),
		.exc       (exc)
	);

endmodule

`default_nettype wire

// ==== verif/tlbTb.sv ====
/*
 TLB testbench: a Wishbone master drives loads, stores, LDTLB and INVTLB
 into the MMU TLB and each result is checked against a reference model
*/
`default_nettype none
`timescale 1ns/1ps

`include "tlb_defs.svh"

module tlbTb;
	import tlbPkg::*;

	localparam int clockPeriod = 20;
	localparam int plannedRequests = 92;
	localparam int topBit = `TLB_VADDR_W - 1;
	localparam int ackWaitLimit = 20;

	logic                      clock;
	logic                      reset;
	logic                      cyc;
	logic                      stb;
	tlbOpT                     op;
	logic [`TLB_VADDR_W-1:0]   adr;
	logic [`TLB_ENTRY_W-1:0]   datIn;
	logic                      mmuEnable;
	logic                      ack;
	logic [`TLB_VADDR_W-1:0]   physAdr;
	tlbExcT                    exc;

	int          errors;
	int          requests;
	logic [31:0] lcgState;

	// reference copy of the sets
	logic [`TLB_VPN_W-1:0] refVpn [`TLB_SETS][`TLB_WAYS];
	logic [`TLB_VPN_W-1:0] refPpn [`TLB_SETS][`TLB_WAYS];
	logic                  refWritable [`TLB_SETS][`TLB_WAYS];
	logic                  refValid [`TLB_SETS][`TLB_WAYS];

	// expected {exc, address} values in request order
	logic [`TLB_VADDR_W+1:0] expectQ [$];
	logic [`TLB_VADDR_W+1:0] expectedNow;

	logic [`TLB_VADDR_W-1:0] testAdr;
	logic [`TLB_VPN_W-1:0]   testVpn;
	logic [`TLB_VPN_W-1:0]   pageVpn [12];
	logic [`TLB_VPN_W-1:0]   evictVpn [5];

	mmuTlb i_dut (
		.clock     (clock),
		.reset     (reset),
		.cyc       (cyc),
		.stb       (stb),
		.op        (op),
		.adr       (adr),
		.datIn     (datIn),
		.mmuEnable (mmuEnable),
		.ack       (ack),
		.physAdr   (physAdr),
		.exc       (exc)
	);

	always #(clockPeriod / 2) clock = ~clock;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic randomBit();
		logic [31:0] r;
		r = nextRand();
		return r[16];
	endfunction

	function automatic logic [`TLB_VADDR_W-1:0] randomAdr();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRand();
		lo = nextRand();
		return {hi[31:16], lo};
	endfunction

	// top nibble kept below C so mapped pages never fall in the physical window
	function automatic logic [`TLB_VPN_W-1:0] randomVpn();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRand();
		lo = nextRand();
		return {2'b00, hi[17:16], lo};
	endfunction

	// every other page gets a zero top nibble
	function automatic logic [`TLB_VPN_W-1:0] randomPpn(input int n);
		logic [31:0] hi;
		logic [31:0] lo;
		logic [`TLB_VPN_W-1:0] ppn;
		hi = nextRand();
		lo = nextRand();
		ppn = {hi[19:16], lo};
		if (n % 2 == 0)
		begin
			ppn[`TLB_VPN_W-1 -: 4] = 4'h0;
		end
		return ppn;
	endfunction

	function automatic logic [`TLB_ENTRY_W-1:0] entryWord(input logic [`TLB_VPN_W-1:0] vpn,
		input logic [`TLB_VPN_W-1:0] ppn, input logic writable);
		tlbEntryT e;
		e.vpn = vpn;
		e.ppn = ppn;
		e.writable = writable;
		return {{(`TLB_ENTRY_W - $bits(tlbEntryT)){1'b0}}, e};
	endfunction

	// newest entry goes to way 0 and the oldest way falls off
	function automatic void insertEntry(input logic [`TLB_VPN_W-1:0] vpn,
		input logic [`TLB_VPN_W-1:0] ppn, input logic writable);
		logic [`TLB_INDEX_W-1:0] set;
		set = vpn[`TLB_INDEX_W-1:0];
		for (int w = `TLB_WAYS - 1; w > 0; w--)
		begin
			refVpn[set][w] = refVpn[set][w-1];
			refPpn[set][w] = refPpn[set][w-1];
			refWritable[set][w] = refWritable[set][w-1];
			refValid[set][w] = refValid[set][w-1];
		end
		refVpn[set][0] = vpn;
		refPpn[set][0] = ppn;
		refWritable[set][0] = writable;
		refValid[set][0] = 1'b1;
	endfunction

	function automatic void invalidateAll();
		for (int s = 0; s < `TLB_SETS; s++)
		begin
			for (int w = 0; w < `TLB_WAYS; w++)
			begin
				refValid[s][w] = 1'b0;
			end
		end
	endfunction

	// expected {exc, address} for one request against the current model
	function automatic logic [`TLB_VADDR_W+1:0] expectedResult(input tlbOpT reqOp,
		input logic [`TLB_VADDR_W-1:0] reqAdr, input logic enable);
		logic [`TLB_VPN_W-1:0]   vpn;
		logic [`TLB_INDEX_W-1:0] set;
		logic [`TLB_VADDR_W-1:0] result;
		logic [3:0]              top;
		tlbExcT                  reqExc;
		logic                    found;
		vpn = reqAdr[topBit:`TLB_PAGE_SHIFT];
		set = vpn[`TLB_INDEX_W-1:0];
		top = reqAdr[topBit -: 4];
		result = reqAdr;
		reqExc = excNone;
		found = 1'b0;
		if (reqOp == opLoad || reqOp == opStore)
		begin
			if (!enable || top == 4'hC || top == 4'hD)
			begin
				result[topBit -: 4] = 4'hC;
			end
			else
			begin
				result = {`TLB_MISS_PAGE, reqAdr[`TLB_PAGE_SHIFT-1:0]};
				reqExc = excMiss;
				for (int w = 0; w < `TLB_WAYS; w++)
				begin
					if (!found && refValid[set][w] && refVpn[set][w] == vpn)
					begin
						found = 1'b1;
						result = {refPpn[set][w], reqAdr[`TLB_PAGE_SHIFT-1:0]};
						if (result[topBit -: 4] == 4'h0)
						begin
							result[topBit -: 4] = 4'hC;
						end
						reqExc = excNone;
						if (reqOp == opStore && !refWritable[set][w])
						begin
							reqExc = excWriteProt;
						end
					end
				end
			end
		end
		return {reqExc, result};
	endfunction

	task automatic checkValue(input logic [63:0] got, input logic [63:0] want,
		input string what);
		if (got !== want)
		begin
			errors++;
			$display("ERR %0t ns: %s got %h expected %h", $time, what, got, want);
		end
	endtask

	// one Wishbone classic transfer held until ack
	task automatic busCycle(input tlbOpT reqOp, input logic [`TLB_VADDR_W-1:0] reqAdr,
		input logic [`TLB_ENTRY_W-1:0] reqDat);
		tlbEntryT e;
		int cycles;
		@(posedge clock);
		#2;
		expectQ.push_back(expectedResult(reqOp, reqAdr, mmuEnable));
		e = tlbEntryT'(reqDat[$bits(tlbEntryT)-1:0]);
		if (reqOp == opLdtlb)
		begin
			insertEntry(e.vpn, e.ppn, e.writable);
		end
		else if (reqOp == opInvtlb)
		begin
			invalidateAll();
		end
		cyc = 1'b1;
		stb = 1'b1;
		op = reqOp;
		adr = reqAdr;
		datIn = reqDat;
		requests++;
		// wait for the sample edge and count cycles until ack
		@(posedge clock);
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!ack && cycles < ackWaitLimit);
		if (!ack)
		begin
			errors++;
			$display("No acknowledge for request %0d after %0d cycles", requests, cycles);
		end
		else
		begin
			checkValue(cycles, 3, "ack latency");
		end
		@(posedge clock);
		#2;
		cyc = 1'b0;
		stb = 1'b0;
		@(negedge clock);
		checkValue(ack, 1'b0, "ack width");
	endtask

	// compares every acknowledged result with the model
	always @(negedge clock)
	begin
		if (!reset && ack)
		begin
			if (expectQ.size() == 0)
			begin
				errors++;
				$display("Acknowledge at %0t ns with no request outstanding", $time);
			end
			else
			begin
				expectedNow = expectQ.pop_front();
				checkValue(physAdr, expectedNow[`TLB_VADDR_W-1:0], "physical address");
				checkValue(exc, expectedNow[`TLB_VADDR_W +: 2], "exception");
			end
		end
	end

	initial
	begin
		#(plannedRequests * 10 * clockPeriod + 50 * clockPeriod);
		$display("Watchdog expired at %0t ns, the test sequence did not finish", $time);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		lcgState = 32'd71532;
		errors = 0;
		requests = 0;
		clock = 1'b0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		op = opLoad;
		adr = '0;
		datIn = '0;
		mmuEnable = 1'b0;
		invalidateAll();
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;

		// with the MMU off all loads go to window C
		for (int i = 0; i < 8; i++)
		begin
			busCycle(opLoad, randomAdr(), '0);
		end

		// physical window with the MMU on and nothing mapped
		@(posedge clock);
		#2;
		mmuEnable = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			testAdr = randomAdr();
			testAdr[topBit -: 4] = (i % 2 == 1) ? 4'hD : 4'hC;
			busCycle(opLoad, testAdr, '0);
		end

		// random inserts followed by loads and stores on them
		for (int i = 0; i < 12; i++)
		begin
			pageVpn[i] = randomVpn();
			busCycle(opLdtlb, randomAdr(), entryWord(pageVpn[i], randomPpn(i), randomBit()));
		end
		for (int i = 0; i < 12; i++)
		begin
			testAdr = randomAdr();
			busCycle(opLoad, {pageVpn[i], testAdr[`TLB_PAGE_SHIFT-1:0]}, '0);
		end
		for (int i = 0; i < 12; i++)
		begin
			testAdr = randomAdr();
			busCycle(opStore, {pageVpn[i], testAdr[`TLB_PAGE_SHIFT-1:0]}, '0);
		end

		// unmapped pages miss
		for (int i = 0; i < 6; i++)
		begin
			testVpn = randomVpn();
			testAdr = randomAdr();
			busCycle((i < 4) ? opLoad : opStore,
				{testVpn, testAdr[`TLB_PAGE_SHIFT-1:0]}, '0);
		end

		// read-only page against a writable one
		testVpn = randomVpn();
		busCycle(opLdtlb, randomAdr(), entryWord(testVpn, randomPpn(1), 1'b0));
		busCycle(opStore, {testVpn, 12'h3a4}, '0);
		busCycle(opLoad, {testVpn, 12'h3a8}, '0);
		testVpn = randomVpn();
		busCycle(opLdtlb, randomAdr(), entryWord(testVpn, randomPpn(2), 1'b1));
		busCycle(opStore, {testVpn, 12'hffc}, '0);

		// five inserts into set 5 push the first one out
		busCycle(opInvtlb, randomAdr(), '0);
		for (int i = 0; i < 5; i++)
		begin
			testVpn = randomVpn();
			evictVpn[i] = {testVpn[`TLB_VPN_W-1:`TLB_INDEX_W], 4'h5};
			busCycle(opLdtlb, randomAdr(), entryWord(evictVpn[i], randomPpn(i), 1'b1));
		end
		for (int i = 0; i < 5; i++)
		begin
			busCycle(opLoad, {evictVpn[i], 12'h010}, '0);
		end

		// nothing survives INVTLB
		busCycle(opInvtlb, randomAdr(), '0);
		for (int i = 0; i < 5; i++)
		begin
			busCycle(opLoad, {evictVpn[i], 12'h020}, '0);
		end
		for (int i = 0; i < 12; i++)
		begin
			busCycle(opLoad, {pageVpn[i], 12'h040}, '0);
		end

		repeat (2) @(negedge clock);
		if (expectQ.size() != 0)
		begin
			errors++;
			$display("%0d expected results were never acknowledged", expectQ.size());
		end
		$display("%0d requests, %0d errors", requests, errors);
		if (errors == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
rtl/tlbPkg.sv
rtl/tlbIf.sv
rtl/tlbRequestStage.sv
rtl/tlbWayArray.sv
rtl/tlbTranslate.sv
rtl/mmuTlb.sv
verif/tlbTb.sv
